//--- logic/vid_defs.svh
`ifndef VID_DEFS_SVH
`define VID_DEFS_SVH

// Pixel and line counts.
`define VID_DIM_W 14

// Payload is line[11:0] above pixel[11:0].
`define VID_DATA_W 24

`define VID_REG_AW 2
`define VID_REG_DW 16

`define VID_ADDR_PIXELS 2'd0
`define VID_ADDR_LINES  2'd1
`define VID_ADDR_CTRL   2'd2
`define VID_ADDR_FRAMES 2'd3

`define VID_CTRL_RUN       0
`define VID_CTRL_INTERLACE 1

`endif

//--- logic/vid_pkg.sv
`include "vid_defs.svh"

package vid_pkg;

  // One pixel or line count.
  typedef logic [`VID_DIM_W-1:0] vid_dim_t;

  // One payload word of the output stream.
  typedef logic [`VID_DATA_W-1:0] vid_data_t;

  // Register map of the configuration block.
  typedef enum logic [`VID_REG_AW-1:0] {
    REG_PIXELS = `VID_ADDR_PIXELS,  // Active pixels per line.
    REG_LINES  = `VID_ADDR_LINES,   // Active lines per frame.
    REG_CTRL   = `VID_ADDR_CTRL,    // Run enable and interlace.
    REG_FRAMES = `VID_ADDR_FRAMES   // Completed frames, read only.
  } vid_reg_e;

endpackage

//--- logic/vid_cfg_regs.sv
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_cfg_regs
  import vid_pkg::*;
(
  input  logic                   aclk,
  input  logic                   rst,
  input  logic                   wr_en,
  input  vid_reg_e               wr_addr,
  input  logic [`VID_REG_DW-1:0] wr_data,
  input  vid_reg_e               rd_addr,
  output logic [`VID_REG_DW-1:0] rd_data,
  input  logic                   frame_done,
  output vid_dim_t               active_pixels,
  output vid_dim_t               active_lines,
  output logic                   run,
  output logic                   interlace
);

  vid_dim_t               sh_pixels;
  vid_dim_t               sh_lines;
  logic                   sh_run;
  logic                   sh_interlace;
  vid_dim_t               live_pixels;
  vid_dim_t               live_lines;
  logic                   live_run;
  logic                   live_interlace;
  logic [`VID_REG_DW-1:0] frame_cnt;
  vid_dim_t               wr_dim;

  // A zero geometry would never end a line, so it is raised to 1.
  assign wr_dim = (wr_data[`VID_DIM_W-1:0] == '0) ? vid_dim_t'(1) : wr_data[`VID_DIM_W-1:0];

  always_ff @(posedge aclk) begin
    if (rst) begin
      sh_pixels    <= vid_dim_t'(1);
      sh_lines     <= vid_dim_t'(1);
      sh_run       <= 1'b0;
      sh_interlace <= 1'b0;
    end else if (wr_en) begin
      case (wr_addr)
        REG_PIXELS: sh_pixels <= wr_dim;
        REG_LINES:  sh_lines  <= wr_dim;
        REG_CTRL: begin
          sh_run       <= wr_data[`VID_CTRL_RUN];
          sh_interlace <= wr_data[`VID_CTRL_INTERLACE];
        end
        default: ;  // Frame count is read only.
      endcase
    end
  end

  // The live set only moves at a frame boundary, or freely while stopped.
  always_ff @(posedge aclk) begin
    if (rst) begin
      live_pixels    <= vid_dim_t'(1);
      live_lines     <= vid_dim_t'(1);
      live_run       <= 1'b0;
      live_interlace <= 1'b0;
      frame_cnt      <= '0;
    end else begin
      if (frame_done || !live_run) begin
        live_pixels    <= sh_pixels;
        live_lines     <= sh_lines;
        live_run       <= sh_run;
        live_interlace <= sh_interlace;
      end
      if (frame_done)
        frame_cnt <= frame_cnt + 16'd1;  // Wraps at 16 bits.
    end
  end

  // During frame_done the generator already sees the new set, since it
  // picks the settings of the next frame on that same edge.
  assign active_pixels = frame_done ? sh_pixels : live_pixels;
  assign active_lines  = frame_done ? sh_lines : live_lines;
  assign run           = frame_done ? sh_run : live_run;
  assign interlace     = frame_done ? sh_interlace : live_interlace;

  always_comb begin
    rd_data = '0;
    case (rd_addr)
      REG_PIXELS: rd_data[`VID_DIM_W-1:0] = sh_pixels;
      REG_LINES:  rd_data[`VID_DIM_W-1:0] = sh_lines;
      REG_CTRL: begin
        rd_data[`VID_CTRL_RUN]       = sh_run;
        rd_data[`VID_CTRL_INTERLACE] = sh_interlace;
      end
      default:    rd_data = frame_cnt;
    endcase
  end

endmodule

//--- logic/vid_pattern_gen.sv
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_pattern_gen
  import vid_pkg::*;
(
  input  logic      aclk,
  input  logic      rst,
  input  vid_dim_t  active_pixels,
  input  vid_dim_t  active_lines,
  input  logic      run,
  input  logic      interlace,
  input  logic      tready,
  output logic      tvalid,
  output vid_data_t tdata,
  output logic      tlast,
  output logic      tuser_sof,
  output logic      fid,
  output logic      line_pulse,
  output logic      frame_done
);

  localparam int CW = `VID_DATA_W / 2;  // Width of one coordinate field.

  vid_dim_t pix_cnt;
  vid_dim_t line_cnt;
  vid_dim_t frm_pixels;
  vid_dim_t frm_lines;
  logic     frm_interlace;
  logic     accept;
  logic     last_of_frame;
  logic     load;
  logic     new_frame;
  logic     nx_valid;
  vid_dim_t nx_pix;
  vid_dim_t nx_line;
  vid_dim_t nx_pixels;
  logic     nx_interlace;
  logic     nx_fid;

  // The counters hold the position of the beat on the output.
  assign accept        = tvalid & tready;
  assign last_of_frame = tlast & (line_cnt == frm_lines - vid_dim_t'(1));
  assign frame_done    = accept & last_of_frame;
  assign load          = ~tvalid | accept;   // A new beat may be presented.
  assign new_frame     = ~tvalid | last_of_frame;
  assign nx_valid      = ~new_frame | run;   // A frame only starts while running.

  always_comb begin
    if (new_frame) begin
      nx_pix  = '0;
      nx_line = '0;
    end else if (tlast) begin
      nx_pix  = '0;
      nx_line = line_cnt + vid_dim_t'(1);
    end else begin
      nx_pix  = pix_cnt + vid_dim_t'(1);
      nx_line = line_cnt;
    end
  end

  // Geometry and mode are taken from the live set only at a frame start.
  assign nx_pixels    = new_frame ? active_pixels : frm_pixels;
  assign nx_interlace = new_frame ? interlace : frm_interlace;

  // The first interlaced frame out of idle or progressive is field 0.
  always_comb begin
    if (new_frame)
      nx_fid = run & interlace & tvalid & frm_interlace & ~fid;
    else
      nx_fid = fid;
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      tvalid        <= 1'b0;
      tlast         <= 1'b0;
      tuser_sof     <= 1'b0;
      fid           <= 1'b0;
      pix_cnt       <= '0;
      line_cnt      <= '0;
      frm_pixels    <= vid_dim_t'(1);
      frm_lines     <= vid_dim_t'(1);
      frm_interlace <= 1'b0;
    end else if (load) begin
      tvalid    <= nx_valid;
      tlast     <= nx_valid & (nx_pix == nx_pixels - vid_dim_t'(1));
      tuser_sof <= new_frame & run;
      fid       <= nx_fid;
      pix_cnt   <= nx_pix;
      line_cnt  <= nx_line;
      if (new_frame) begin
        frm_pixels    <= active_pixels;
        frm_lines     <= active_lines;
        frm_interlace <= interlace;
      end
    end
  end

  // Field 1 carries the inverted coordinate word.
  always_ff @(posedge aclk) begin
    if (load)
      tdata <= {nx_line[CW-1:0], nx_pix[CW-1:0]} ^ {`VID_DATA_W{nx_interlace & nx_fid}};
  end

  // Pulses once after each accepted end of line, whatever tready does next.
  always_ff @(posedge aclk) begin
    if (rst)
      line_pulse <= 1'b0;
    else
      line_pulse <= accept & tlast;
  end

endmodule

//--- logic/vid_pattern_top.sv
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_pattern_top
  import vid_pkg::*;
(
  input  logic                   aclk,
  input  logic                   rst,
  input  logic                   wr_en,
  input  vid_reg_e               wr_addr,
  input  logic [`VID_REG_DW-1:0] wr_data,
  input  vid_reg_e               rd_addr,
  output logic [`VID_REG_DW-1:0] rd_data,
  input  logic                   tready,
  output logic                   tvalid,
  output vid_data_t              tdata,
  output logic                   tlast,
  output logic                   tuser_sof,
  output logic                   fid,
  output logic                   line_pulse
);

  vid_dim_t active_pixels;
  vid_dim_t active_lines;
  logic     run;
  logic     interlace;
  logic     frame_done;

  // Settings and frame count.
  vid_cfg_regs u_cfg (
    .aclk          (aclk),
    .rst           (rst),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .frame_done    (frame_done),
    .active_pixels (active_pixels),
    .active_lines  (active_lines),
    .run           (run),
    .interlace     (interlace)
  );

  vid_pattern_gen u_gen (
    .aclk          (aclk),
    .rst           (rst),
    .active_pixels (active_pixels),
    .active_lines  (active_lines),
    .run           (run),
    .interlace     (interlace),
    .tready        (tready),
    .tvalid        (tvalid),
    .tdata         (tdata),
    .tlast         (tlast),
    .tuser_sof     (tuser_sof),
    .fid           (fid),
    .line_pulse    (line_pulse),
    .frame_done    (frame_done)   // Ends a frame and releases the shadows.
  );

endmodule

//--- test/vid_pattern_props.sv
`timescale 1ns/1ps
`include "vid_defs.svh"

module vid_pattern_props
  import vid_pkg::*;
(
  input logic      aclk,
  input logic      rst,
  input logic      tready,
  input logic      tvalid,
  input vid_data_t tdata,
  input logic      tlast,
  input logic      tuser_sof,
  input logic      fid,
  input logic      line_pulse,
  input logic      interlace
);

  int unsigned fail_cnt = 0;  // Read by the testbench at the end of the run.

  // Reset is synchronous, so the stream is quiet one edge later.
  reset_idle: assert property (@(posedge aclk) rst |=> !tvalid)
    else begin
      $error("tvalid is high after a reset cycle");
      fail_cnt++;
    end

  hold_stable: assert property (@(posedge aclk) disable iff (rst)
    tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tlast)
                          && $stable(tuser_sof) && $stable(fid))
    else begin
      $error("Stream beat changed while held by back-pressure");
      fail_cnt++;
    end

  pulse_after_last: assert property (@(posedge aclk) disable iff (rst)
    tvalid && tready && tlast |=> line_pulse)
    else begin
      $error("No line_pulse after an accepted end of line");
      fail_cnt++;
    end

  pulse_only_after_last: assert property (@(posedge aclk) disable iff (rst)
    line_pulse |-> $past(tvalid && tready && tlast))
    else begin
      $error("line_pulse without an accepted end of line");
      fail_cnt++;
    end

  // Field 0 beats carry the plain coordinate word, so a frame start is pixel 0.
  sof_at_pixel_zero: assert property (@(posedge aclk) disable iff (rst)
    tvalid && tuser_sof && !fid |-> tdata[`VID_DATA_W/2-1:0] == '0)
    else begin
      $error("tuser_sof on a beat with a nonzero pixel field");
      fail_cnt++;
    end

  fid_progressive: assert property (@(posedge aclk) disable iff (rst)
    !interlace |=> !fid)
    else begin
      $error("fid is set while interlace is off");
      fail_cnt++;
    end

endmodule

bind vid_pattern_top vid_pattern_props u_props (
  .aclk       (aclk),
  .rst        (rst),
  .tready     (tready),
  .tvalid     (tvalid),
  .tdata      (tdata),
  .tlast      (tlast),
  .tuser_sof  (tuser_sof),
  .fid        (fid),
  .line_pulse (line_pulse),
  .interlace  (interlace)
);

//--- test/tb_vid_pattern.sv
`timescale 1ns/1ps

module tb_vid_pattern
  import vid_pkg::*;
();

  localparam int TIMEOUT = 200;  // Cycles without an accepted beat.

  logic        aclk;
  logic        rst;
  logic        wr_en;
  vid_reg_e    wr_addr;
  logic [15:0] wr_data;
  vid_reg_e    rd_addr;
  logic [15:0] rd_data;
  logic        tready;
  logic        tvalid;
  vid_data_t   tdata;
  logic        tlast;
  logic        tuser_sof;
  logic        fid;
  logic        line_pulse;
  logic [31:0] rnd;
  logic        timed_out;
  int          errors;
  int          bad_tests;
  int          frames_seen;

  vid_pattern_top u_dut (
    .aclk       (aclk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .tready     (tready),
    .tvalid     (tvalid),
    .tdata      (tdata),
    .tlast      (tlast),
    .tuser_sof  (tuser_sof),
    .fid        (fid),
    .line_pulse (line_pulse)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Line number above pixel number, inverted for field 1.
  function automatic vid_data_t coord_word(input int x, input int y, input logic inv);
    vid_data_t w;
    w = {y[11:0], x[11:0]};
    if (inv)
      w = ~w;
    return w;
  endfunction

  task automatic report_mismatch(input string what);
    $display("Mismatch at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic close_test(input string name, input int err_mark);
    if (errors == err_mark) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - err_mark);
      bad_tests++;
    end
  endtask

  task automatic write_reg(input vid_reg_e addr, input logic [15:0] value);
    @(posedge aclk);
    wr_en   <= 1'b1;
    wr_addr <= addr;
    wr_data <= value;
    @(posedge aclk);
    wr_en <= 1'b0;
  endtask

  task automatic read_check(input vid_reg_e addr, input logic [15:0] expected);
    @(posedge aclk);
    rd_addr <= addr;
    @(posedge aclk);
    assert (rd_data == expected)
      else report_mismatch($sformatf("%s read %0d, expected %0d", addr.name(), rd_data, expected));
  endtask

  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      @(posedge aclk);
      assert (!tvalid) else report_mismatch("tvalid high while the stream is stopped");
    end
  endtask

  // Takes one frame under random ready, with an optional write after beat wr_beat.
  task automatic run_frame(input int npix, input int nlines, input logic exp_fid,
                           input int wr_beat, input vid_reg_e wr_reg,
                           input logic [15:0] wr_val, output logic valid_after);
    int beats;
    int idle;
    int pulses;
    int x;
    int y;
    beats  = 0;
    idle   = 0;
    pulses = 0;
    while (beats < npix * nlines && !timed_out) begin
      @(posedge aclk);
      wr_en <= 1'b0;
      if (line_pulse)
        pulses++;
      if (tvalid && tready) begin
        x = beats % npix;
        y = beats / npix;
        assert (tdata == coord_word(x, y, exp_fid))
          else report_mismatch($sformatf("payload %h at pixel %0d line %0d", tdata, x, y));
        assert (tlast == (x == npix - 1))
          else report_mismatch($sformatf("tlast %b at pixel %0d line %0d", tlast, x, y));
        assert (tuser_sof == (beats == 0))
          else report_mismatch($sformatf("tuser_sof %b at pixel %0d line %0d", tuser_sof, x, y));
        assert (fid == exp_fid)
          else report_mismatch($sformatf("fid %b, expected %b", fid, exp_fid));
        beats++;
        idle = 0;
        if (beats == wr_beat) begin
          wr_en   <= 1'b1;
          wr_addr <= wr_reg;
          wr_data <= wr_val;
        end
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          $display("Timeout at %0t: no beat accepted for %0d cycles", $time, TIMEOUT);
          timed_out = 1'b1;
        end
      end
      rnd = next_random(rnd);
      tready <= (beats == npix * nlines) ? 1'b0 : (rnd[1:0] != 2'b00);
    end
    @(posedge aclk);  // The pulse of the last line arrives here.
    wr_en <= 1'b0;
    if (line_pulse)
      pulses++;
    valid_after = tvalid;
    frames_seen++;
    assert (pulses == nlines)
      else report_mismatch($sformatf("%0d line pulses, expected %0d", pulses, nlines));
  endtask

  initial begin
    logic valid_after;
    int   err_mark;
    rst       = 1'b1;
    wr_en     = 1'b0;
    wr_addr   = REG_PIXELS;
    wr_data   = '0;
    rd_addr   = REG_PIXELS;
    tready    = 1'b0;
    rnd       = 32'd19117;
    timed_out = 1'b0;
    repeat (8) @(posedge aclk);
    rst <= 1'b0;

    err_mark = errors;
    expect_idle(20);
    read_check(REG_PIXELS, 16'd1);
    read_check(REG_LINES, 16'd1);
    read_check(REG_CTRL, 16'd0);
    read_check(REG_FRAMES, 16'd0);
    close_test("reset and idle", err_mark);

    err_mark = errors;
    write_reg(REG_PIXELS, 16'd8);
    write_reg(REG_LINES, 16'd4);
    write_reg(REG_CTRL, 16'd1);
    run_frame(8, 4, 1'b0, 0, REG_CTRL, 16'd0, valid_after);
    close_test("progressive frame", err_mark);

    // Interlace written mid-frame starts with field 0 on the next frame.
    err_mark = errors;
    run_frame(8, 4, 1'b0, 5, REG_CTRL, 16'd3, valid_after);
    run_frame(8, 4, 1'b0, 0, REG_CTRL, 16'd0, valid_after);
    run_frame(8, 4, 1'b1, 0, REG_CTRL, 16'd0, valid_after);
    close_test("interlace", err_mark);

    err_mark = errors;
    run_frame(8, 4, 1'b0, 10, REG_PIXELS, 16'd6, valid_after);
    run_frame(6, 4, 1'b1, 0, REG_CTRL, 16'd0, valid_after);
    close_test("frame-boundary update", err_mark);

    err_mark = errors;
    run_frame(6, 4, 1'b0, 7, REG_CTRL, 16'd0, valid_after);
    assert (!valid_after) else report_mismatch("tvalid still high after the last beat");
    expect_idle(20);
    read_check(REG_FRAMES, 16'(frames_seen));
    close_test("stop and frame count", err_mark);

    $display("Tests: 5, with errors: %0d, errors: %0d, assertion failures: %0d",
             bad_tests, errors, u_dut.u_props.fail_cnt);
    if (errors == 0 && bad_tests == 0 && !timed_out && u_dut.u_props.fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+logic
logic/vid_pkg.sv
logic/vid_cfg_regs.sv
logic/vid_pattern_gen.sv
logic/vid_pattern_top.sv
test/vid_pattern_props.sv
test/tb_vid_pattern.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
verilator --binary --assert --timing --top-module tb_vid_pattern -f tb.f -o vtb &&
./obj_dir/vtb +verilator+error+limit+100 | tee sim.log
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
